//--- rs.f
+incdir+hdl
hdl/rs_pkg.sv
hdl/rs_skid_slice.sv
hdl/rs_regreq_fanout.sv
hdl/rs_ctrl_bcast.sv
hdl/rs_chain_slices.sv
hdl/rs_top.sv
verif/rs_clk_gen.sv
verif/rs_tb.sv

//--- run_sim.sh
#!/bin/bash
# builds rs_tb with Verilator, runs it and scans the log for a failure
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rs_tb -f rs.f -o rs_sim
./obj_dir/rs_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- verif/rs_tb.sv
// table driven testbench for rs_top, inputs change 1 ns after the rising edge
// stream ids are 0 rd, 1 dwr, then one command per chain, then one event per chain
`timescale 1ns/1ns
`default_nettype none

`include "rs_macros.svh"

module rs_tb;

  import rs_pkg::*;

  localparam int NCH   = `RS_CHAIN_NUM;
  localparam int NDST  = `RS_DEST_NUM;
  localparam int NSTR  = 2 + 2 * NCH;
  localparam int NROWS = 11;

  logic        user_clk;
  logic        reset_n;
  dest_vec_t   regreq_valid, regreq_valid_rs;
  regreq_t     regreq;
  regreq_vec_t regreq_rs;
  cfg_t        cfg;
  cfg_vec_t    cfg_rs;
  dbg_ctrl_t   dbg;
  dbg_vec_t    dbg_rs;
  logic        timer_pulse, timer_pulse_rs;
  logic        rd_valid_rs, rd_ready_rs, rd_valid, rd_ready;
  logic        dwr_valid_rs, dwr_ready_rs, dwr_valid, dwr_ready;
  axis_beat_t  rd_beat_rs, rd_beat, dwr_beat_rs, dwr_beat;
  chain_vec_t  cmd_valid, cmd_ready, cmd_valid_rs, cmd_ready_rs;
  chain_vec_t  eve_valid_rs, eve_ready_rs, eve_valid, eve_ready;
  cmd_vec_t    cmd_data, cmd_data_rs;
  eve_vec_t    eve_data_rs, eve_data;

  // generic view of every stream, source side and sink side
  logic [NSTR-1:0] src_valid, sink_rdy, in_rdy, out_vld, fired;
  logic [512:0]    src_data [NSTR];
  logic [512:0]    out_dat [NSTR];
  logic [512:0]    exp_q [NSTR][$];
  int              acc_q [NSTR][$];
  int              occ [NSTR];
  int              recv [NSTR];
  regreq_vec_t     shadow;

  string       row_name [NROWS];
  string       row_chan [NROWS];
  logic [7:0]  row_mask [NROWS];
  int          row_beats [NROWS];
  logic [31:0] row_seed [NROWS];
  int          row_stall [NROWS];
  int          row_hold [NROWS];
  int          cyc, limit, mism, other_err, cur_row;
  bit          check_lat;

  rs_clk_gen clk_gen_i (
    .user_clk (user_clk),
    .reset_n  (reset_n)
  );

  rs_top dut_i (.*);

  assign rd_valid_rs  = src_valid[0];
  assign dwr_valid_rs = src_valid[1];
  assign cmd_valid    = src_valid[1+NCH:2];
  assign eve_valid_rs = src_valid[NSTR-1:2+NCH];
  assign rd_beat_rs   = src_data[0];
  assign dwr_beat_rs  = src_data[1];
  assign rd_ready     = sink_rdy[0];
  assign dwr_ready    = sink_rdy[1];
  assign cmd_ready_rs = sink_rdy[1+NCH:2];
  assign eve_ready    = sink_rdy[NSTR-1:2+NCH];
  assign in_rdy       = {eve_ready_rs, cmd_ready, dwr_ready_rs, rd_ready_rs};
  assign out_vld      = {eve_valid, cmd_valid_rs, dwr_valid, rd_valid};

  always_comb begin
    out_dat[0] = rd_beat;
    out_dat[1] = dwr_beat;
    for (int c = 0; c < NCH; c++) begin
      cmd_data[c]          = src_data[2 + c][`RS_CMD_W-1:0];
      eve_data_rs[c]       = src_data[2 + NCH + c][`RS_EVE_W-1:0];
      out_dat[2 + c]       = 513'(cmd_data_rs[c]);
      out_dat[2 + NCH + c] = 513'(eve_data[c]);
    end
  end

  task automatic add_row(input int idx, input string name, input string chan,
                         input logic [7:0] mask, input int beats, input logic [31:0] seed,
                         input int stall, input int hold);
    row_name[idx]  = name;
    row_chan[idx]  = chan;
    row_mask[idx]  = mask;
    row_beats[idx] = beats;
    row_seed[idx]  = seed;
    row_stall[idx] = stall;
    row_hold[idx]  = hold;
  endtask

  task automatic report_mismatch(input string test, input string exp_s, input string act_s);
    mism++;
    $display("CHECK FAILED %s: expected %s, actual %s", test, exp_s, act_s);
  endtask

  task automatic print_counts();
    $display("value mismatches %0d, other errors %0d", mism, other_err);
  endtask

  // random payload, low word carries a tag to find the beat in a log
  function automatic logic [576:0] rand_word(input logic [31:0] tag);
    logic [607:0] acc;
    acc = '0;
    for (int k = 0; k < 19; k++) begin
      acc = {acc[575:0], $urandom};
    end
    acc[31:0] = tag;
    return acc[576:0];
  endfunction

  function automatic logic [512:0] make_beat(input int s, input int r, input int i);
    logic [576:0] w;
    logic [512:0] m;
    w = rand_word(row_seed[r] + 32'(s << 16) + 32'(i));
    m = '1;
    if (s >= 2 + NCH) m = m >> (513 - `RS_EVE_W);
    else if (s >= 2) m = m >> (513 - `RS_CMD_W);
    return w[512:0] & m;
  endfunction

  function automatic logic [NSTR-1:0] active_streams(input string chan, input logic [7:0] m);
    logic [NSTR-1:0] act;
    act = '0;
    if (chan == "rd") act[0] = 1'b1;
    if (chan == "dwr") act[1] = 1'b1;
    if (chan == "cmd" || chan == "chain") act[1+NCH:2] = m[NCH-1:0];
    if (chan == "eve" || chan == "chain") act[NSTR-1:2+NCH] = m[NCH-1:0];
    return act;
  endfunction

  task automatic count_cycles();
    while (cyc < limit) begin
      @(posedge user_clk);
      cyc++;
    end
    other_err++;
    $display("timeout after %0d cycles in %s, beats stopped moving", cyc, row_name[cur_row]);
    print_counts();
    $display("TEST FAILED");
    $finish;
  endtask

  // everything seen at the falling edge transfers on the next rising edge
  task automatic track_streams();
    logic [512:0] want;
    int t0;
    forever begin
      @(negedge user_clk);
      for (int s = 0; s < NSTR; s++) begin
        if (in_rdy[s] !== (occ[s] < 2)) begin
          other_err++;
          $display("%s: stream %0d ready is %b while holding %0d beats",
                   row_name[cur_row], s, in_rdy[s], occ[s]);
        end
        if (out_vld[s] && sink_rdy[s]) begin
          if (exp_q[s].size() == 0) begin
            other_err++;
            $display("%s: stream %0d delivered a beat that was never sent", row_name[cur_row], s);
          end else begin
            want = exp_q[s].pop_front();
            t0 = acc_q[s].pop_front();
            occ[s]--;
            recv[s]++;
            if (out_dat[s] !== want)
              report_mismatch(row_name[cur_row], $sformatf("%h", want),
                              $sformatf("%h", out_dat[s]));
            if (check_lat && cyc - t0 != 1) begin
              other_err++;
              $display("%s: stream %0d beat took %0d cycles", row_name[cur_row], s, cyc - t0);
            end
          end
        end
        fired[s] = src_valid[s] && in_rdy[s];
        if (fired[s]) begin
          exp_q[s].push_back(src_data[s]);
          acc_q[s].push_back(cyc);
          occ[s]++;
        end
      end
    end
  endtask

  task automatic fan_out_requests(input int r);
    logic [31:0] rnd;
    dest_vec_t vld;
    regreq_t req;
    for (int i = 0; i < row_beats[r]; i++) begin
      rnd = $urandom;
      vld = row_mask[r][NDST-1:0] & rnd[NDST-1:0];
      req = rand_word(row_seed[r] + 32'(i));
      regreq_valid = vld;
      regreq = req;
      @(posedge user_clk);
      #1;
      if (regreq_valid_rs !== vld)
        report_mismatch(row_name[r], $sformatf("%h", vld), $sformatf("%h", regreq_valid_rs));
      for (int d = 0; d < NDST; d++) begin
        if (vld[d]) shadow[d] = req;
        if (regreq_rs[d] !== shadow[d])
          report_mismatch(row_name[r], $sformatf("%h", shadow[d]),
                          $sformatf("%h", regreq_rs[d]));
      end
    end
    regreq_valid = '0;
    @(posedge user_clk);
    #1;
    if (regreq_valid_rs !== '0)
      report_mismatch(row_name[r], "0", $sformatf("%h", regreq_valid_rs));
  endtask

  task automatic copy_controls(input int r);
    logic [31:0] rnd;
    cfg_t c;
    dbg_ctrl_t g;
    for (int i = 0; i < row_beats[r]; i++) begin
      rnd = $urandom;
      c = rnd[4:0];
      g = {rnd[8:5], row_seed[r] + 32'(i)};
      cfg = c;
      dbg = g;
      timer_pulse = rnd[9];
      @(posedge user_clk);
      #1;
      for (int e = 0; e < 2; e++) begin
        if (cfg_rs[e] !== c)
          report_mismatch(row_name[r], $sformatf("%h", c), $sformatf("%h", cfg_rs[e]));
      end
      for (int d = 0; d < NDST; d++) begin
        if (dbg_rs[d] !== g)
          report_mismatch(row_name[r], $sformatf("%h", g), $sformatf("%h", dbg_rs[d]));
      end
      if (timer_pulse_rs !== rnd[9])
        report_mismatch(row_name[r], $sformatf("%b", rnd[9]), $sformatf("%b", timer_pulse_rs));
    end
    timer_pulse = 1'b0;
  endtask

  // a held chain sees no ready until every other stream has drained
  task automatic stream_beats(input int r);
    logic [NSTR-1:0] act;
    int sent [NSTR];
    int base [NSTR];
    int held;
    bit busy;
    bit others_done;
    act = active_streams(row_chan[r], row_mask[r]);
    held = (row_hold[r] >= 0) ? 2 + row_hold[r] : -1;
    check_lat = (row_stall[r] == 0) && (held < 0);
    for (int s = 0; s < NSTR; s++) begin
      sent[s] = 0;
      base[s] = recv[s];
      src_valid[s] = act[s];
      if (act[s]) src_data[s] = make_beat(s, r, 0);
    end
    busy = 1'b1;
    while (busy) begin
      @(posedge user_clk);
      #1;
      busy = 1'b0;
      others_done = 1'b1;
      for (int s = 0; s < NSTR; s++) begin
        if (fired[s]) begin
          sent[s]++;
          if (sent[s] < row_beats[r]) src_data[s] = make_beat(s, r, sent[s]);
          else src_valid[s] = 1'b0;
        end
        if (act[s] && recv[s] - base[s] < row_beats[r]) begin
          busy = 1'b1;
          if (s != held) others_done = 1'b0;
        end
      end
      for (int s = 0; s < NSTR; s++) begin
        if (s == held && !others_done) sink_rdy[s] = 1'b0;
        else sink_rdy[s] = ($urandom % 100) >= row_stall[r];
      end
    end
    sink_rdy = '1;
    for (int s = 0; s < NSTR; s++) begin
      if (exp_q[s].size() != 0) begin
        other_err++;
        $display("%s: stream %0d kept %0d beats undelivered", row_name[r], s, exp_q[s].size());
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf682_8981));
    regreq_valid = '0;
    regreq = '0;
    cfg = '0;
    dbg = '0;
    timer_pulse = 1'b0;
    src_valid = '0;
    sink_rdy = '1;
    shadow = '0;
    for (int s = 0; s < NSTR; s++) begin
      src_data[s] = '0;
      occ[s] = 0;
      recv[s] = 0;
    end
    {cyc, mism, other_err, cur_row, check_lat} = '0;
    //       name           chan      mask   beats seed   stall hold
    add_row(0,  "regreq_all",  "regreq", 8'hf, 16, 32'h100, 0,  -1);
    add_row(1,  "regreq_some", "regreq", 8'h5, 16, 32'h200, 0,  -1);
    add_row(2,  "ctrl_copy",   "ctrl",   8'h0, 16, 32'h300, 0,  -1);
    add_row(3,  "rd_flow",     "rd",     8'h1, 32, 32'h400, 0,  -1);
    add_row(4,  "dwr_flow",    "dwr",    8'h1, 32, 32'h500, 0,  -1);
    add_row(5,  "rd_stall",    "rd",     8'h1, 48, 32'h600, 40, -1);
    add_row(6,  "dwr_stall",   "dwr",    8'h1, 48, 32'h700, 60, -1);
    add_row(7,  "cmd_stall",   "cmd",    8'hf, 40, 32'h800, 50, -1);
    add_row(8,  "eve_stall",   "eve",    8'hf, 40, 32'h900, 50, -1);
    add_row(9,  "chain_hold0", "chain",  8'hf, 24, 32'ha00, 30, 0);
    add_row(10, "chain_hold3", "chain",  8'hb, 24, 32'hb00, 30, 3);
    limit = 100;
    for (int r = 0; r < NROWS; r++) limit += row_beats[r] * 20;
    fork
      count_cycles();
      track_streams();
    join_none

    @(posedge reset_n);
    @(posedge user_clk);
    #1;
    if (regreq_valid_rs !== '0 || regreq_rs !== '0 || timer_pulse_rs !== 1'b0)
      report_mismatch("reset", "0", $sformatf("%h %h %b", regreq_valid_rs, regreq_rs,
                                              timer_pulse_rs));
    if (cfg_rs !== '0 || dbg_rs !== '0)
      report_mismatch("reset", "0", $sformatf("%h %h", cfg_rs, dbg_rs));
    if (out_vld !== '0)
      report_mismatch("reset", "0", $sformatf("%h", out_vld));
    if (in_rdy !== '1)
      report_mismatch("reset", $sformatf("%h", {NSTR{1'b1}}), $sformatf("%h", in_rdy));
    for (int s = 0; s < NSTR; s++) begin
      if (out_dat[s] !== '0)
        report_mismatch("reset", "0", $sformatf("%h", out_dat[s]));
    end

    for (int r = 0; r < NROWS; r++) begin
      cur_row = r;
      if (row_chan[r] == "regreq") fan_out_requests(r);
      else if (row_chan[r] == "ctrl") copy_controls(r);
      else stream_beats(r);
    end

    print_counts();
    if (mism + other_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rs_clk_gen.sv
// clock and reset for the rs testbench
// reset_n is released 1 ns after the last reset edge, away from the sampling point
`timescale 1ns/1ns
`default_nettype none

module rs_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic user_clk,
  output logic reset_n
);

  initial begin
    user_clk = 1'b0;
    forever #(PERIOD_NS / 2) user_clk = ~user_clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge user_clk);
    #1 reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- hdl/rs_top.sv
// register slice between the PCIe transaction engine, DMA engines and chain logic
// every path adds exactly one cycle, streams keep full throughput
`timescale 1ns/1ns
`default_nettype none

`include "rs_macros.svh"

module rs_top (
  input  logic                user_clk,
  input  logic                reset_n,

  // register requests, no back-pressure
  input  rs_pkg::dest_vec_t   regreq_valid,
  input  rs_pkg::regreq_t     regreq,
  output rs_pkg::dest_vec_t   regreq_valid_rs,
  output rs_pkg::regreq_vec_t regreq_rs,

  input  rs_pkg::cfg_t        cfg,
  output rs_pkg::cfg_vec_t    cfg_rs,
  input  rs_pkg::dbg_ctrl_t   dbg,
  output rs_pkg::dbg_vec_t    dbg_rs,
  input  logic                timer_pulse,
  output logic                timer_pulse_rs,

  // DMA read requests, _rs side in
  input  logic                rd_valid_rs,
  input  rs_pkg::axis_beat_t  rd_beat_rs,
  output logic                rd_ready_rs,
  output logic                rd_valid,
  output rs_pkg::axis_beat_t  rd_beat,
  input  logic                rd_ready,

  // DMA write data, _rs side in
  input  logic                dwr_valid_rs,
  input  rs_pkg::axis_beat_t  dwr_beat_rs,
  output logic                dwr_ready_rs,
  output logic                dwr_valid,
  output rs_pkg::axis_beat_t  dwr_beat,
  input  logic                dwr_ready,

  // per-chain commands in on the plain side, events in on the _rs side
  input  rs_pkg::chain_vec_t  cmd_valid,
  input  rs_pkg::cmd_vec_t    cmd_data,
  output rs_pkg::chain_vec_t  cmd_ready,
  output rs_pkg::chain_vec_t  cmd_valid_rs,
  output rs_pkg::cmd_vec_t    cmd_data_rs,
  input  rs_pkg::chain_vec_t  cmd_ready_rs,
  input  rs_pkg::chain_vec_t  eve_valid_rs,
  input  rs_pkg::eve_vec_t    eve_data_rs,
  output rs_pkg::chain_vec_t  eve_ready_rs,
  output rs_pkg::chain_vec_t  eve_valid,
  output rs_pkg::eve_vec_t    eve_data,
  input  rs_pkg::chain_vec_t  eve_ready
);

  import rs_pkg::*;

  localparam int BEAT_W = $bits(axis_beat_t);

  rs_regreq_fanout regreq_fanout (
    .user_clk        (user_clk),
    .reset_n         (reset_n),
    .regreq_valid    (regreq_valid),
    .regreq          (regreq),
    .regreq_valid_rs (regreq_valid_rs),
    .regreq_rs       (regreq_rs)
  );

  rs_ctrl_bcast ctrl_bcast (
    .user_clk       (user_clk),
    .reset_n        (reset_n),
    .cfg            (cfg),
    .dbg            (dbg),
    .timer_pulse    (timer_pulse),
    .cfg_rs         (cfg_rs),
    .dbg_rs         (dbg_rs),
    .timer_pulse_rs (timer_pulse_rs)
  );

  rs_skid_slice #(.DATA_W(BEAT_W)) rd_slice (
    .user_clk  (user_clk),
    .reset_n   (reset_n),
    .in_valid  (rd_valid_rs),
    .in_data   (rd_beat_rs),
    .in_ready  (rd_ready_rs),
    .out_valid (rd_valid),
    .out_data  (rd_beat),
    .out_ready (rd_ready)
  );

  rs_skid_slice #(.DATA_W(BEAT_W)) dwr_slice (
    .user_clk  (user_clk),
    .reset_n   (reset_n),
    .in_valid  (dwr_valid_rs),
    .in_data   (dwr_beat_rs),
    .in_ready  (dwr_ready_rs),
    .out_valid (dwr_valid),
    .out_data  (dwr_beat),
    .out_ready (dwr_ready)
  );

  rs_chain_slices #(.CHAIN_NUM(`RS_CHAIN_NUM)) chain_slices (
    .user_clk     (user_clk),
    .reset_n      (reset_n),
    .cmd_valid    (cmd_valid),
    .cmd_data     (cmd_data),
    .cmd_ready    (cmd_ready),
    .cmd_valid_rs (cmd_valid_rs),
    .cmd_data_rs  (cmd_data_rs),
    .cmd_ready_rs (cmd_ready_rs),
    .eve_valid_rs (eve_valid_rs),
    .eve_data_rs  (eve_data_rs),
    .eve_ready_rs (eve_ready_rs),
    .eve_valid    (eve_valid),
    .eve_data     (eve_data),
    .eve_ready    (eve_ready)
  );

endmodule

`default_nettype wire

//--- hdl/rs_chain_slices.sv
// command and event slices, one pair per chain, each chain stalls on its own
// CHAIN_NUM must match RS_CHAIN_NUM since the port vectors are sized by the macro
`timescale 1ns/1ns
`default_nettype none

`include "rs_macros.svh"

module rs_chain_slices #(
  parameter int CHAIN_NUM = `RS_CHAIN_NUM
) (
  input  logic               user_clk,
  input  logic               reset_n,
  input  rs_pkg::chain_vec_t cmd_valid,
  input  rs_pkg::cmd_vec_t   cmd_data,
  output rs_pkg::chain_vec_t cmd_ready,
  output rs_pkg::chain_vec_t cmd_valid_rs,
  output rs_pkg::cmd_vec_t   cmd_data_rs,
  input  rs_pkg::chain_vec_t cmd_ready_rs,
  input  rs_pkg::chain_vec_t eve_valid_rs,
  input  rs_pkg::eve_vec_t   eve_data_rs,
  output rs_pkg::chain_vec_t eve_ready_rs,
  output rs_pkg::chain_vec_t eve_valid,
  output rs_pkg::eve_vec_t   eve_data,
  input  rs_pkg::chain_vec_t eve_ready
);

  for (genvar c = 0; c < CHAIN_NUM; c++) begin : g_chain
    // commands travel toward the chain logic
    rs_skid_slice #(.DATA_W(`RS_CMD_W)) cmd_slice (
      .user_clk  (user_clk),
      .reset_n   (reset_n),
      .in_valid  (cmd_valid[c]),
      .in_data   (cmd_data[c]),
      .in_ready  (cmd_ready[c]),
      .out_valid (cmd_valid_rs[c]),
      .out_data  (cmd_data_rs[c]),
      .out_ready (cmd_ready_rs[c])
    );

    // events come back from the chain logic
    rs_skid_slice #(.DATA_W(`RS_EVE_W)) eve_slice (
      .user_clk  (user_clk),
      .reset_n   (reset_n),
      .in_valid  (eve_valid_rs[c]),
      .in_data   (eve_data_rs[c]),
      .in_ready  (eve_ready_rs[c]),
      .out_valid (eve_valid[c]),
      .out_data  (eve_data[c]),
      .out_ready (eve_ready[c])
    );
  end

endmodule

`default_nettype wire

//--- hdl/rs_ctrl_bcast.sv
// one register stage of config, debug/trace controls and the timer pulse
// config goes to dmar and dmat only, debug/trace to all four consumers
`timescale 1ns/1ns
`default_nettype none

`include "rs_macros.svh"

module rs_ctrl_bcast (
  input  logic              user_clk,
  input  logic              reset_n,
  input  rs_pkg::cfg_t      cfg,
  input  rs_pkg::dbg_ctrl_t dbg,
  input  logic              timer_pulse,
  output rs_pkg::cfg_vec_t  cfg_rs,
  output rs_pkg::dbg_vec_t  dbg_rs,
  output logic              timer_pulse_rs
);

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_rs         <= '0;
      dbg_rs         <= '0;
      timer_pulse_rs <= 1'b0;
    end else begin
      // entry 0 dmar, entry 1 dmat
      cfg_rs         <= {2{cfg}};
      dbg_rs         <= {`RS_DEST_NUM{dbg}};
      // single cycle pulse, delayed one edge
      timer_pulse_rs <= timer_pulse;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rs_regreq_fanout.sv
// registered fan-out of one register request to four consumers
// each consumer has its own copy, reloaded only when its valid bit is set
`timescale 1ns/1ns
`default_nettype none

`include "rs_macros.svh"

module rs_regreq_fanout (
  input  logic                user_clk,
  input  logic                reset_n,
  input  rs_pkg::dest_vec_t   regreq_valid,
  input  rs_pkg::regreq_t     regreq,
  output rs_pkg::dest_vec_t   regreq_valid_rs,
  output rs_pkg::regreq_vec_t regreq_rs
);

  // valid bits are copied every cycle, no hold
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      regreq_valid_rs <= '0;
    end else begin
      regreq_valid_rs <= regreq_valid;
    end
  end

  // unaddressed copies keep their last request
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      regreq_rs <= '0;
    end else begin
      for (int d = 0; d < `RS_DEST_NUM; d++) begin
        if (regreq_valid[d]) begin
          regreq_rs[d] <= regreq;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rs_skid_slice.sv
// two-entry valid/ready slice, one beat per cycle while the sink keeps up
// in_ready is a flop output, so out_ready never reaches in_ready combinationally
`timescale 1ns/1ns
`default_nettype none

module rs_skid_slice #(
  parameter int DATA_W = 64
) (
  input  logic              user_clk,
  input  logic              reset_n,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  input  logic              out_ready
);

  logic              main_valid;
  logic [DATA_W-1:0] main_data;
  logic              skid_valid;
  logic [DATA_W-1:0] skid_data;
  logic              main_free;
  logic              in_fire;

  // main entry may load when empty or when it drains this cycle
  assign main_free = ~main_valid | out_ready;
  assign in_fire   = in_valid & in_ready;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      main_valid <= 1'b0;
      main_data  <= '0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // skid entry always goes first to keep order
      if (skid_valid) begin
        main_valid <= 1'b1;
        main_data  <= skid_data;
      end else begin
        main_valid <= in_fire;
        if (in_fire) begin
          main_data <= in_data;
        end
      end
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  // second beat parks here while main is stalled
  always_ff @(posedge user_clk) begin
    if (!main_free && in_fire) begin
      skid_data <= in_data;
    end
  end

  assign in_ready  = ~skid_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  // stalled output holds until taken
  a_out_hold: assert property (@(posedge user_clk) disable iff (!reset_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  // skid entry only ever fills behind a held main entry
  a_skid_behind_main: assert property (@(posedge user_clk) disable iff (!reset_n)
    skid_valid |-> main_valid);

endmodule

`default_nettype wire

//--- hdl/rs_pkg.sv
// types for the rs register slices, sized by the macros header
// destination index order everywhere is dmar, dmat, cifdn, cifup
`default_nettype none

`include "rs_macros.svh"

package rs_pkg;

  // bit 0 dmar, 1 dmat, 2 cifdn, 3 cifup
  typedef logic [`RS_DEST_NUM-1:0] dest_vec_t;

  typedef struct packed {
    logic [`RS_DATA_W-1:0] tdata;
    logic                  tlast;
    logic [`RS_USER_W-1:0] tuser;
  } regreq_t;

  typedef regreq_t [`RS_DEST_NUM-1:0] regreq_vec_t;

  typedef struct packed {
    logic [`RS_DATA_W-1:0] tdata;
    logic                  tlast;
  } axis_beat_t;

  typedef struct packed {
    logic [2:0] max_read_req;
    logic [1:0] max_payload;
  } cfg_t;

  // entry 0 dmar, entry 1 dmat
  typedef cfg_t [1:0] cfg_vec_t;

  typedef struct packed {
    logic        dbg_enable;
    logic        dbg_count_reset;
    logic        dma_trace_enable;
    logic        dma_trace_rst;
    logic [31:0] freerun_count;
  } dbg_ctrl_t;

  typedef dbg_ctrl_t [`RS_DEST_NUM-1:0] dbg_vec_t;

  typedef logic [`RS_CHAIN_NUM-1:0]                 chain_vec_t;
  typedef logic [`RS_CHAIN_NUM-1:0][`RS_CMD_W-1:0]  cmd_vec_t;
  typedef logic [`RS_CHAIN_NUM-1:0][`RS_EVE_W-1:0]  eve_vec_t;

endpackage

`default_nettype wire

//--- hdl/rs_macros.svh
// widths and counts shared by the rs register slices
// RS_CHAIN_NUM also sizes the per-chain port vectors, so every chain parameter follows it
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// register request and DMA stream payload
`define RS_DATA_W     512
`define RS_USER_W     64

// per-chain transfer command and event words
`define RS_CMD_W      64
`define RS_EVE_W      128

// chains on the command/event side
`define RS_CHAIN_NUM  4

// dmar, dmat, cifdn, cifup
`define RS_DEST_NUM   4

`endif
